// File: design/vga_pkg.sv
package vga_pkg;

  typedef logic [11:0] coord_t;  // screen coordinate
  typedef logic [11:0] rgb_t;    // 4 bits per channel, r g b

  ////////////////////
  // 1024x768 at 60 Hz, 65 MHz pixel clock

  localparam coord_t H_ACTIVE     = 12'd1024;
  localparam coord_t H_SYNC_START = 12'd1048;
  localparam coord_t H_SYNC_WIDTH = 12'd136;
  localparam coord_t H_TOTAL      = 12'd1344;

  localparam coord_t V_ACTIVE     = 12'd768;
  localparam coord_t V_SYNC_START = 12'd771;
  localparam coord_t V_SYNC_WIDTH = 12'd6;
  localparam coord_t V_TOTAL      = 12'd806;

  ////////////////////
  // one pixel slot of the sweep

  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;  // high inside the sync pulse
    logic   vsync;
    logic   blank;  // outside the active area
  } pixel_pos_t;

  localparam rgb_t COLOR_LASER = 12'hfff;  // white
  localparam rgb_t COLOR_BLACK = 12'h000;

endpackage

// File: design/game_pkg.sv
package game_pkg;

  ////////////////////
  // laser geometry

  localparam vga_pkg::coord_t LASER_LEFT  = 12'd361;
  localparam vga_pkg::coord_t LASER_RIGHT = 12'd661;

  // first row of each 2 pixel seed
  localparam vga_pkg::coord_t ROW_TOP    = 12'd367;
  localparam vga_pkg::coord_t ROW_MIDDLE = 12'd467;
  localparam vga_pkg::coord_t ROW_BOTTOM = 12'd567;

  localparam logic [5:0] LASER_SPREAD = 6'd30;  // per edge
  localparam logic [3:0] LASER_LEVEL  = 4'b0010;

  typedef enum logic [1:0] {
    idle,
    draw_top,
    draw_middle,
    draw_bottom
  } laser_state_t;

  ////////////////////
  // control and status

  typedef struct packed {
    logic            game_on;
    logic            menu_on;
    logic            play_selected;
    logic [3:0]      selected;
    logic            start;     // one cycle
    vga_pkg::coord_t player_x;
    vga_pkg::coord_t player_y;
    vga_pkg::rgb_t   bg_color;
  } game_ctrl_t;

  typedef struct packed {
    logic            valid;
    vga_pkg::coord_t obstacle_x;
    vga_pkg::coord_t obstacle_y;
  } obstacle_pix_t;

  typedef struct packed {
    logic       working;
    logic       done_seen;
    logic       hit;
    logic [7:0] hit_count;
    logic [5:0] lasers_left;
  } game_stat_t;

  localparam logic [3:0] REG_CTRL   = 4'h0;
  localparam logic [3:0] REG_PLAYER = 4'h4;
  localparam logic [3:0] REG_BG     = 4'h8;
  localparam logic [3:0] REG_STATUS = 4'hc;

endpackage

// File: design/vga_timing.sv
module vga_timing (
  input  logic                pclk,
  input  logic                rst,
  output vga_pkg::pixel_pos_t pos
);

  vga_pkg::coord_t hcount;
  vga_pkg::coord_t vcount;
  logic            h_last;
  logic            v_last;

  assign h_last = (hcount == vga_pkg::H_TOTAL - 12'd1);
  assign v_last = (vcount == vga_pkg::V_TOTAL - 12'd1);

  ////////////////////
  // counters

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
    end else begin
      if (h_last) begin
        hcount <= '0;
        if (v_last) begin
          vcount <= '0;
        end else begin
          vcount <= vcount + 12'd1;
        end
      end else begin
        hcount <= hcount + 12'd1;
      end
    end
  end

  ////////////////////
  // sync and blank from the counters

  always_comb begin
    pos.hcount = hcount;
    pos.vcount = vcount;
    pos.hsync  = (hcount >= vga_pkg::H_SYNC_START) &&
                 (hcount < vga_pkg::H_SYNC_START + vga_pkg::H_SYNC_WIDTH);
    pos.vsync  = (vcount >= vga_pkg::V_SYNC_START) &&
                 (vcount < vga_pkg::V_SYNC_START + vga_pkg::V_SYNC_WIDTH);
    // front porch, sync and back porch all count as blank
    pos.blank  = (hcount >= vga_pkg::H_ACTIVE) || (vcount >= vga_pkg::V_ACTIVE);
  end

endmodule

// File: design/apb_game_regs.sv
module apb_game_regs (
  input  logic                 pclk,
  input  logic                 rst,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [3:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output game_pkg::game_ctrl_t ctrl,
  input  logic                 working,
  input  logic                 done,
  input  logic                 hit_pulse,
  input  logic [7:0]           count,
  input  logic [5:0]           lasers_left
);

  logic                 access;
  logic                 wr;
  logic                 rd_status;
  logic                 mapped;
  logic                 done_seen;
  logic                 hit;
  game_pkg::game_stat_t stat;

  assign access = psel && penable;
  assign wr     = access && pwrite;
  assign mapped = (paddr == game_pkg::REG_CTRL) || (paddr == game_pkg::REG_PLAYER) ||
                  (paddr == game_pkg::REG_BG) || (paddr == game_pkg::REG_STATUS);
  assign rd_status = access && !pwrite && (paddr == game_pkg::REG_STATUS);

  assign pready  = 1'b1;  // no wait states
  assign pslverr = access && !mapped;

  ////////////////////
  // control fields

  always_ff @(posedge pclk) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      ctrl.start <= wr && (paddr == game_pkg::REG_CTRL) && pwdata[8];
      if (wr && (paddr == game_pkg::REG_CTRL)) begin
        ctrl.game_on       <= pwdata[0];
        ctrl.menu_on       <= pwdata[1];
        ctrl.play_selected <= pwdata[2];
        ctrl.selected      <= pwdata[7:4];
      end
      if (wr && (paddr == game_pkg::REG_PLAYER)) begin
        ctrl.player_x <= pwdata[11:0];
        ctrl.player_y <= pwdata[27:16];
      end
      if (wr && (paddr == game_pkg::REG_BG)) ctrl.bg_color <= pwdata[11:0];
    end
  end

  // sticky until read, a new event wins over the clear
  always_ff @(posedge pclk) begin
    if (rst) begin
      done_seen <= 1'b0;
      hit       <= 1'b0;
    end else begin
      done_seen <= (done_seen && !rd_status) || done;
      hit       <= (hit && !rd_status) || hit_pulse;
    end
  end

  always_comb begin
    stat.working     = working;
    stat.done_seen   = done_seen;
    stat.hit         = hit;
    stat.hit_count   = count;
    stat.lasers_left = lasers_left;
    case (paddr)
      game_pkg::REG_CTRL:   prdata = {23'd0, 1'b0, ctrl.selected, 1'b0, ctrl.play_selected,
                                      ctrl.menu_on, ctrl.game_on};
      game_pkg::REG_PLAYER: prdata = {4'd0, ctrl.player_y, 4'd0, ctrl.player_x};
      game_pkg::REG_BG:     prdata = {20'd0, ctrl.bg_color};
      game_pkg::REG_STATUS: prdata = {15'd0, stat};
      default:              prdata = 32'd0;
    endcase
  end

endmodule

// File: design/horizontal_lasers_obstacle.sv
module horizontal_lasers_obstacle #(
  parameter logic [23:0] ON_DELAY    = 24'd3_200_000,
  parameter logic [23:0] GAP_DELAY   = 24'd16_000_000,
  parameter logic [5:0]  LASER_COUNT = 6'd16
) (
  input  logic                    pclk,
  input  logic                    rst,
  input  vga_pkg::pixel_pos_t     pos,
  input  game_pkg::game_ctrl_t    ctrl,
  output vga_pkg::rgb_t           rgb_out,
  output vga_pkg::pixel_pos_t     vga_out,
  output game_pkg::obstacle_pix_t pix,
  output logic                    working,
  output logic                    done,
  output logic [5:0]              lasers_left
);

  game_pkg::laser_state_t state, state_nxt;
  logic [5:0]             spread, spread_nxt;   // edge offset from the seed
  logic [23:0]            timer, timer_nxt;
  logic [5:0]             left_nxt;
  logic                   done_nxt;
  logic [23:0]            limit;
  logic                   step;
  logic                   arm_ok;
  logic                   abort;
  vga_pkg::coord_t        row_start;
  vga_pkg::coord_t        band_top;
  vga_pkg::coord_t        band_bot;
  logic                   on_laser;

  function automatic game_pkg::laser_state_t next_row(input game_pkg::laser_state_t s);
    case (s)
      game_pkg::draw_top:    next_row = game_pkg::draw_middle;
      game_pkg::draw_middle: next_row = game_pkg::draw_bottom;
      default:               next_row = game_pkg::draw_top;
    endcase
  endfunction

  assign arm_ok = ctrl.play_selected && !ctrl.menu_on && (ctrl.selected == game_pkg::LASER_LEVEL);
  assign abort  = ctrl.menu_on || !ctrl.play_selected;

  // widening runs on ON_DELAY, both holds on GAP_DELAY
  assign limit = ((spread != 6'd0) && (spread != game_pkg::LASER_SPREAD)) ? ON_DELAY : GAP_DELAY;
  assign step  = (timer == limit - 24'd1);

  ////////////////////
  // sequencer

  always_comb begin
    state_nxt  = state;
    spread_nxt = spread;
    timer_nxt  = timer;
    left_nxt   = lasers_left;
    done_nxt   = 1'b0;
    case (state)
      game_pkg::idle: begin
        if (ctrl.start && arm_ok) begin
          state_nxt  = game_pkg::draw_top;
          spread_nxt = 6'd0;
          timer_nxt  = 24'd0;
          left_nxt   = LASER_COUNT;
        end
      end
      default: begin
        if (abort) begin
          state_nxt = game_pkg::idle;  // no done on abort
          timer_nxt = 24'd0;
          left_nxt  = 6'd0;
        end else if (!step) begin
          timer_nxt = timer + 24'd1;
        end else begin
          timer_nxt = 24'd0;
          if (spread != game_pkg::LASER_SPREAD) begin
            spread_nxt = spread + 6'd1;
          end else if (lasers_left <= 6'd1) begin
            state_nxt  = game_pkg::idle;
            spread_nxt = 6'd0;
            left_nxt   = 6'd0;
            done_nxt   = 1'b1;
          end else begin
            state_nxt  = next_row(state);
            spread_nxt = 6'd0;
            left_nxt   = lasers_left - 6'd1;
          end
        end
      end
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      state       <= game_pkg::idle;
      spread      <= '0;
      timer       <= '0;
      lasers_left <= '0;
      done        <= 1'b0;
      working     <= 1'b0;
    end else begin
      state       <= state_nxt;
      spread      <= spread_nxt;
      timer       <= timer_nxt;
      lasers_left <= left_nxt;
      done        <= done_nxt;
      working     <= (state_nxt != game_pkg::idle);
    end
  end

  ////////////////////
  // pixel overlay

  always_comb begin
    case (state)
      game_pkg::draw_middle: row_start = game_pkg::ROW_MIDDLE;
      game_pkg::draw_bottom: row_start = game_pkg::ROW_BOTTOM;
      default:               row_start = game_pkg::ROW_TOP;
    endcase
    band_top = row_start - {6'd0, spread};
    band_bot = row_start + {6'd0, spread} + 12'd1;  // seed is two rows
    on_laser = (state != game_pkg::idle) && !pos.blank &&
               (pos.hcount >= game_pkg::LASER_LEFT) && (pos.hcount <= game_pkg::LASER_RIGHT) &&
               (pos.vcount >= band_top) && (pos.vcount <= band_bot);
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      rgb_out   <= vga_pkg::COLOR_BLACK;
      pix.valid <= 1'b0;
    end else begin
      pix.valid <= on_laser;
      if (pos.blank) rgb_out <= vga_pkg::COLOR_BLACK;
      else if (on_laser) rgb_out <= vga_pkg::COLOR_LASER;
      else rgb_out <= ctrl.bg_color;
    end
  end

  // position follows every pixel, valid qualifies it
  always_ff @(posedge pclk) begin
    vga_out        <= pos;
    pix.obstacle_x <= pos.hcount;
    pix.obstacle_y <= pos.vcount;
  end

endmodule

// File: design/laser_collision.sv
module laser_collision #(
  parameter logic [11:0] PLAYER_W = 12'd40,
  parameter logic [11:0] PLAYER_H = 12'd40
) (
  input  logic                    pclk,
  input  logic                    rst,
  input  game_pkg::obstacle_pix_t pix,
  input  game_pkg::game_ctrl_t    ctrl,
  output logic                    hit_pulse,
  output logic [7:0]              count
);

  logic            in_box;
  logic            frame_hit;  // already hit this frame
  logic            new_frame;
  vga_pkg::coord_t prev_y;

  // 13 bit sums so the box edge cannot wrap
  assign in_box = ({1'b0, pix.obstacle_x} >= {1'b0, ctrl.player_x}) &&
                  ({1'b0, pix.obstacle_x} < {1'b0, ctrl.player_x} + {1'b0, PLAYER_W}) &&
                  ({1'b0, pix.obstacle_y} >= {1'b0, ctrl.player_y}) &&
                  ({1'b0, pix.obstacle_y} < {1'b0, ctrl.player_y} + {1'b0, PLAYER_H});

  assign new_frame = (pix.obstacle_y < prev_y);
  assign hit_pulse = pix.valid && in_box && !frame_hit;

  always_ff @(posedge pclk) begin
    if (rst) begin
      frame_hit <= 1'b0;
      prev_y    <= '0;
      count     <= '0;
    end else begin
      prev_y <= pix.obstacle_y;
      if (new_frame) frame_hit <= 1'b0;
      else if (hit_pulse) frame_hit <= 1'b1;
      if (hit_pulse && (count != 8'hff)) begin
        count <= count + 8'd1;  // saturates
      end
    end
  end

endmodule

// File: design/laser_game_top.sv
module laser_game_top #(
  parameter logic [23:0] ON_DELAY    = 24'd3_200_000,
  parameter logic [23:0] GAP_DELAY   = 24'd16_000_000,
  parameter logic [5:0]  LASER_COUNT = 6'd16,
  parameter logic [11:0] PLAYER_W    = 12'd40,
  parameter logic [11:0] PLAYER_H    = 12'd40
) (
  input  logic                pclk,
  input  logic                rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [3:0]          paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output vga_pkg::rgb_t       rgb_out,
  output vga_pkg::pixel_pos_t vga_out,
  output logic                working,
  output logic                done
);

  vga_pkg::pixel_pos_t     pos;
  game_pkg::game_ctrl_t    ctrl;
  game_pkg::obstacle_pix_t pix;
  logic                    hit_pulse;
  logic [7:0]              count;
  logic [5:0]              lasers_left;

  vga_timing u_timing (.pclk(pclk), .rst(rst), .pos(pos));

  apb_game_regs u_regs (
    .pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .ctrl(ctrl), .working(working), .done(done), .hit_pulse(hit_pulse),
    .count(count), .lasers_left(lasers_left)
  );

  horizontal_lasers_obstacle #(
    .ON_DELAY(ON_DELAY), .GAP_DELAY(GAP_DELAY), .LASER_COUNT(LASER_COUNT)
  ) u_lasers (
    .pclk(pclk), .rst(rst), .pos(pos), .ctrl(ctrl), .rgb_out(rgb_out), .vga_out(vga_out),
    .pix(pix), .working(working), .done(done), .lasers_left(lasers_left)
  );

  laser_collision #(.PLAYER_W(PLAYER_W), .PLAYER_H(PLAYER_H)) u_collision (
    .pclk(pclk), .rst(rst), .pix(pix), .ctrl(ctrl), .hit_pulse(hit_pulse), .count(count)
  );

endmodule

// File: dv/laser_game_chk.sv
module laser_game_chk #(
  parameter logic [23:0] ON_DELAY    = 24'd4,
  parameter logic [23:0] GAP_DELAY   = 24'd16,
  parameter logic [5:0]  LASER_COUNT = 6'd4
) (
  input logic                pclk,
  input logic                rst,
  input logic                psel,
  input logic                penable,
  input logic                pwrite,
  input logic [3:0]          paddr,
  input logic [31:0]         pwdata,
  input logic                pready,
  input logic                pslverr,
  input vga_pkg::rgb_t       rgb_out,
  input vga_pkg::pixel_pos_t vga_out,
  input logic                working,
  input logic                done
);
  timeunit 1ns;
  timeprecision 100ps;

  // per laser: two holds plus the widening steps
  localparam int MIN_RUN = int'(LASER_COUNT) *
    (2 * int'(GAP_DELAY) + (int'(game_pkg::LASER_SPREAD) - 1) * int'(ON_DELAY));
  localparam int MAX_RUN = int'(LASER_COUNT) *
    (2 * int'(GAP_DELAY) + int'(game_pkg::LASER_SPREAD) * int'(ON_DELAY));

  logic          access;
  logic          ctrl_wr;
  logic          mapped;
  logic          abort_wr;
  logic          in_cols;
  logic          in_band;
  logic          start_q;  // mirrors the start pulse
  logic          arm_q;
  vga_pkg::rgb_t bg_q;
  int            run_len;
  int unsigned   fails = 0;

  function automatic logic near_row(input vga_pkg::coord_t v, input vga_pkg::coord_t row);
    return (v + 12'(game_pkg::LASER_SPREAD) >= row) &&
           (v <= row + 12'(game_pkg::LASER_SPREAD) + 12'd1);
  endfunction

  assign access   = psel && penable;
  assign ctrl_wr  = access && pwrite && (paddr == 4'h0);
  assign mapped   = (paddr == 4'h0) || (paddr == 4'h4) || (paddr == 4'h8) || (paddr == 4'hc);
  assign abort_wr = ctrl_wr && (!pwdata[2] || pwdata[1]);
  assign in_cols  = (vga_out.hcount >= game_pkg::LASER_LEFT) &&
                    (vga_out.hcount <= game_pkg::LASER_RIGHT);
  assign in_band  = near_row(vga_out.vcount, game_pkg::ROW_TOP) ||
                    near_row(vga_out.vcount, game_pkg::ROW_MIDDLE) ||
                    near_row(vga_out.vcount, game_pkg::ROW_BOTTOM);

  always_ff @(posedge pclk) begin
    if (rst) begin
      start_q <= 1'b0;
      arm_q   <= 1'b0;
      bg_q    <= '0;
      run_len <= 0;
    end else begin
      start_q <= ctrl_wr && pwdata[8];
      if (ctrl_wr) arm_q <= pwdata[2] && !pwdata[1] && (pwdata[7:4] == game_pkg::LASER_LEVEL);
      if (access && pwrite && (paddr == 4'h8)) bg_q <= pwdata[11:0];
      run_len <= working ? run_len + 1 : 0;  // length of the current run
    end
  end

  ////////////////////
  // reset and bus

  a_reset_idle: assert property (@(posedge pclk) $past(rst) && !rst |-> !working && !done)
    else begin
      fails++;
      $error("working or done high after reset");
    end
  a_pready: assert property (@(posedge pclk) disable iff (rst) access |-> pready)
    else begin
      fails++;
      $error("pready low in an access phase");
    end
  a_slverr: assert property (@(posedge pclk) disable iff (rst) pslverr == (access && !mapped))
    else begin
      fails++;
      $error("pslverr does not match the address map");
    end

  ////////////////////
  // pixels

  a_sync: assert property (@(posedge pclk) disable iff (rst)
    vga_out.hsync == (vga_out.hcount >= vga_pkg::H_SYNC_START &&
                      vga_out.hcount < vga_pkg::H_SYNC_START + vga_pkg::H_SYNC_WIDTH) &&
    vga_out.vsync == (vga_out.vcount >= vga_pkg::V_SYNC_START &&
                      vga_out.vcount < vga_pkg::V_SYNC_START + vga_pkg::V_SYNC_WIDTH))
    else begin
      fails++;
      $error("sync does not follow the pixel position");
    end
  a_blank_black: assert property (@(posedge pclk) disable iff (rst)
    vga_out.blank |-> rgb_out == vga_pkg::COLOR_BLACK)
    else begin
      fails++;
      $error("colour during blank");
    end
  a_background: assert property (@(posedge pclk) disable iff (rst)
    !vga_out.blank && !(in_cols && in_band && $past(working)) |-> rgb_out == $past(bg_q))
    else begin
      fails++;
      $error("background colour not passed through");
    end
  a_laser_place: assert property (@(posedge pclk) disable iff (rst)
    rgb_out == vga_pkg::COLOR_LASER |-> in_cols && in_band)
    else begin
      fails++;
      $error("laser pixel outside the laser area");
    end

  ////////////////////
  // sequencing

  a_start: assert property (@(posedge pclk) disable iff (rst)
    start_q && arm_q && !working |=> working)
    else begin
      fails++;
      $error("valid start did not raise working");
    end
  a_no_start: assert property (@(posedge pclk) disable iff (rst)
    start_q && !arm_q && !working |=> !working)
    else begin
      fails++;
      $error("start without arming raised working");
    end
  a_done_once: assert property (@(posedge pclk) disable iff (rst) done |=> !done)
    else begin
      fails++;
      $error("done longer than one cycle");
    end
  a_done_end: assert property (@(posedge pclk) disable iff (rst)
    done |-> !working && $past(working) && run_len >= MIN_RUN && run_len <= MAX_RUN)
    else begin
      fails++;
      $error("done at the wrong point of the sequence");
    end
  a_abort: assert property (@(posedge pclk) disable iff (rst)
    $past(abort_wr, 2) |-> !working && !done && !$past(done))
    else begin
      fails++;
      $error("abort did not return to idle cleanly");
    end

endmodule

bind laser_game_top laser_game_chk #(
  .ON_DELAY(ON_DELAY), .GAP_DELAY(GAP_DELAY), .LASER_COUNT(LASER_COUNT)
) chk (
  .pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
  .paddr(paddr), .pwdata(pwdata), .pready(pready), .pslverr(pslverr),
  .rgb_out(rgb_out), .vga_out(vga_out), .working(working), .done(done)
);

// File: dv/laser_game_tb.sv
module laser_game_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [23:0] ON_DELAY     = 24'd4;
  localparam logic [23:0] GAP_DELAY    = 24'd16;
  localparam logic [5:0]  LASER_COUNT  = 6'd4;
  localparam int          CLK_PERIOD   = 8;
  localparam int          FRAME_CYCLES = int'(vga_pkg::H_TOTAL) * int'(vga_pkg::V_TOTAL);
  localparam int          TIMEOUT_NS   = (4 * FRAME_CYCLES + 20000) * CLK_PERIOD;
  localparam int          STAT_DONE    = 15;
  localparam int          STAT_HIT     = 14;
  localparam logic [31:0] CTRL_RUN     = 32'h0000_0125;  // game on, play, level 2, start

  logic                pclk;
  logic                rst;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [3:0]          paddr;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  vga_pkg::rgb_t       rgb_out;
  vga_pkg::pixel_pos_t vga_out;
  logic                working;
  logic                done;

  logic [31:0]     lfsr;
  logic [31:0]     rdata;
  logic [31:0]     wdata;
  vga_pkg::coord_t px;
  vga_pkg::coord_t py;
  int              read_errors;

  laser_game_top #(
    .ON_DELAY(ON_DELAY), .GAP_DELAY(GAP_DELAY), .LASER_COUNT(LASER_COUNT)
  ) dut (
    .pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .rgb_out(rgb_out), .vga_out(vga_out), .working(working), .done(done)
  );

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests finished");
    $display("Regression failed");
    $finish;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  ////////////////////
  // bus tasks

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    @(posedge pclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk);
    #1 penable = 1'b1;
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    @(posedge pclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge pclk);
    #1 penable = 1'b1;
    @(negedge pclk);
    data = prdata;  // mid access phase
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      read_errors++;
    end
  endtask

  task automatic wait_done();
    do begin
      @(posedge pclk);
      #1;
    end while (!done);
  endtask

  task automatic wait_for_pixel(input vga_pkg::coord_t v, input vga_pkg::coord_t h);
    do begin
      @(posedge pclk);
      #1;
    end while (!(vga_out.vcount == v && vga_out.hcount == h));
  endtask

  ////////////////////
  // stimulus

  initial begin
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    lfsr        = 32'hbc47;
    read_errors = 0;
    repeat (5) @(posedge pclk);
    #1 rst = 1'b0;

    wdata = rand_bits(11) << 1;  // lsb clear, never white
    write_reg(4'h8, wdata);
    read_reg(4'h8, rdata);
    check_value("BG", rdata, wdata & 32'h0000_0fff);
    px    = 12'd380 + 12'(rand_bits(6));
    py    = 12'd440 + 12'(rand_bits(4));
    wdata = {4'd0, py, 4'd0, px};
    write_reg(4'h4, wdata);
    read_reg(4'h4, rdata);
    check_value("PLAYER", rdata, wdata);
    write_reg(4'h0, 32'h0000_0025);
    read_reg(4'h0, rdata);
    check_value("CTRL", rdata, 32'h0000_0025);

    write_reg(4'h2, 32'h0000_dead);  // unmapped
    read_reg(4'h6, rdata);

    // wrong level, then menu on
    write_reg(4'h0, 32'h0000_0135);
    repeat (4) @(posedge pclk);
    write_reg(4'h0, 32'h0000_0127);
    repeat (4) @(posedge pclk);

    // abort by clearing play
    write_reg(4'h0, CTRL_RUN);
    repeat (40) @(posedge pclk);
    write_reg(4'h0, 32'h0000_0021);
    repeat (4) @(posedge pclk);

    // middle laser sweeps row 467 across the player box
    read_reg(4'hc, rdata);
    wait_for_pixel(12'd467, 12'd200);
    write_reg(4'h0, CTRL_RUN);
    wait_done();
    read_reg(4'hc, rdata);
    check_value("STATUS hit", 32'(rdata[STAT_HIT]), 32'd1);
    check_value("STATUS done_seen", 32'(rdata[STAT_DONE]), 32'd1);
    if (rdata[13:6] == 8'd0) begin
      $display("ERROR %0t: hit count is zero after a hit", $time);
      read_errors++;
    end
    read_reg(4'hc, rdata);
    check_value("STATUS hit after clear", 32'(rdata[STAT_HIT]), 32'd0);

    // box left of the laser columns, same sweep of row 467
    write_reg(4'h4, {4'd0, 12'(rand_bits(9)), 4'd0, 12'(rand_bits(7))});
    wait_for_pixel(12'd467, 12'd200);
    write_reg(4'h0, CTRL_RUN);
    wait_done();
    read_reg(4'hc, rdata);
    check_value("STATUS hit away", 32'(rdata[STAT_HIT]), 32'd0);
    repeat (4) @(posedge pclk);

    $display("assertion failures %0d, read mismatches %0d", dut.chk.fails, read_errors);
    if (dut.chk.fails == 0 && read_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: laser_game.f
design/vga_pkg.sv
design/game_pkg.sv
design/vga_timing.sv
design/apb_game_regs.sv
design/horizontal_lasers_obstacle.sv
design/laser_collision.sv
design/laser_game_top.sv
dv/laser_game_chk.sv
dv/laser_game_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the laser game regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -Mdir obj_dir \
  --top-module laser_game_tb \
  -f laser_game.f

# keep running past assertion errors so the closing report is printed
status=0
./obj_dir/Vlaser_game_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failures"
